//--- exu_pkg.sv
// execute stage shared types, decode-info field positions and op codes
package exu_pkg;

    typedef logic [31:0] reg_data_t;
    typedef logic [31:0] inst_addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [1:0]  inst_id_t;
    typedef logic [8:0]  dec_info_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  muldiv_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MUL,
        ST_DIV,
        ST_DONE
    } muldiv_state_e;

    // decode-info word layout: grp[8:6] use_imm[5] use_pc[4] op[3:0]
    localparam int DEC_GRP_LSB     = 6;
    localparam int DEC_USE_IMM_BIT = 5;
    localparam int DEC_USE_PC_BIT  = 4;
    localparam int DEC_OP_LSB      = 0;

    localparam logic [2:0] GRP_ALU    = 3'd1;  // 0 is a nop
    localparam logic [2:0] GRP_BJP    = 3'd2;
    localparam logic [2:0] GRP_MULDIV = 3'd3;
    localparam logic [2:0] GRP_SYS    = 3'd4;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;
    localparam alu_op_t ALU_LUI  = 4'd10; // passes operand 2

    localparam logic [2:0] BJP_JAL  = 3'd0;
    localparam logic [2:0] BJP_JALR = 3'd1;
    localparam logic [2:0] BJP_BEQ  = 3'd2;
    localparam logic [2:0] BJP_BNE  = 3'd3;
    localparam logic [2:0] BJP_BLT  = 3'd4;
    localparam logic [2:0] BJP_BGE  = 3'd5;
    localparam logic [2:0] BJP_BLTU = 3'd6;
    localparam logic [2:0] BJP_BGEU = 3'd7;

    localparam muldiv_op_t MD_MUL    = 3'd0;
    localparam muldiv_op_t MD_MULH   = 3'd1;
    localparam muldiv_op_t MD_MULHSU = 3'd2;
    localparam muldiv_op_t MD_MULHU  = 3'd3;
    localparam muldiv_op_t MD_DIV    = 3'd4;
    localparam muldiv_op_t MD_DIVU   = 3'd5;
    localparam muldiv_op_t MD_REM    = 3'd6;
    localparam muldiv_op_t MD_REMU   = 3'd7;

    localparam logic [3:0] SYS_ECALL  = 4'd0;
    localparam logic [3:0] SYS_EBREAK = 4'd1;
    localparam logic [3:0] SYS_MRET   = 4'd2;

    localparam int DIV_STEPS = 32;  // one quotient bit per step

endpackage

//--- exu_dispatch.sv
// decode-info dispatch into unit requests, operands and system op pulses
`timescale 1ns/1ps

module exu_dispatch (
    input  logic                issue_i,
    input  exu_pkg::dec_info_t  dec_info_i,
    input  exu_pkg::reg_data_t  dec_imm_i,
    input  exu_pkg::inst_addr_t pc_i,
    input  exu_pkg::reg_data_t  rs1_data_i,
    input  exu_pkg::reg_data_t  rs2_data_i,
    output logic                alu_req_o,
    output exu_pkg::alu_op_t    alu_op_o,
    output exu_pkg::reg_data_t  alu_op1_o,
    output exu_pkg::reg_data_t  alu_op2_o,
    output logic                bjp_req_o,
    output logic [2:0]          bjp_op_o,
    output logic                md_req_o,
    output exu_pkg::muldiv_op_t md_op_o,
    output exu_pkg::reg_data_t  md_op1_o,
    output exu_pkg::reg_data_t  md_op2_o,
    output logic                ecall_o,
    output logic                ebreak_o,
    output logic                mret_o
);
    import exu_pkg::*;

    logic [2:0] grp;
    logic [3:0] op;
    reg_data_t  op1;
    reg_data_t  op2;
    logic       is_link;
    logic       sys_hit;

    assign grp = dec_info_i[DEC_GRP_LSB +: 3];
    assign op  = dec_info_i[DEC_OP_LSB +: 4];

    assign op1 = dec_info_i[DEC_USE_PC_BIT] ? pc_i : rs1_data_i;
    assign op2 = dec_info_i[DEC_USE_IMM_BIT] ? dec_imm_i : rs2_data_i;

    // jal/jalr also need rd = pc + 4 through the alu
    assign is_link = (grp == GRP_BJP) && ((op[2:0] == BJP_JAL) || (op[2:0] == BJP_JALR));

    assign alu_req_o = issue_i && ((grp == GRP_ALU) || is_link);
    assign alu_op_o  = is_link ? ALU_ADD : op;
    assign alu_op1_o = is_link ? pc_i : op1;
    assign alu_op2_o = is_link ? 32'd4 : op2;

    assign bjp_req_o = issue_i && (grp == GRP_BJP);
    assign bjp_op_o  = op[2:0];

    // muldiv is register-register only
    assign md_req_o = issue_i && (grp == GRP_MULDIV);
    assign md_op_o  = op[2:0];
    assign md_op1_o = rs1_data_i;
    assign md_op2_o = rs2_data_i;

    assign sys_hit  = issue_i && (grp == GRP_SYS);
    assign ecall_o  = sys_hit && (op == SYS_ECALL);
    assign ebreak_o = sys_hit && (op == SYS_EBREAK);
    assign mret_o   = sys_hit && (op == SYS_MRET);

endmodule

//--- exu_alu.sv
// integer ALU with a one-cycle registered write-back
`timescale 1ns/1ps

module exu_alu (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               req_i,
    input  exu_pkg::alu_op_t   op_i,
    input  exu_pkg::reg_data_t op1_i,
    input  exu_pkg::reg_data_t op2_i,
    input  exu_pkg::reg_addr_t rd_i,
    input  exu_pkg::inst_id_t  id_i,
    input  logic               int_assert_i,
    output logic               we_o,
    output exu_pkg::reg_data_t wdata_o,
    output exu_pkg::reg_addr_t waddr_o,
    output exu_pkg::inst_id_t  id_o
);
    import exu_pkg::*;

    reg_data_t  result;
    logic [4:0] shamt;

    assign shamt = op2_i[4:0];  // low 5 bits only

    always_comb begin
        case (op_i)
            ALU_ADD:  result = op1_i + op2_i;
            ALU_SUB:  result = op1_i - op2_i;
            ALU_SLL:  result = op1_i << shamt;
            ALU_SLT:  result = {31'd0, $signed(op1_i) < $signed(op2_i)};
            ALU_SLTU: result = {31'd0, op1_i < op2_i};
            ALU_XOR:  result = op1_i ^ op2_i;
            ALU_SRL:  result = op1_i >> shamt;
            ALU_SRA:  result = reg_data_t'($signed(op1_i) >>> shamt);
            ALU_OR:   result = op1_i | op2_i;
            ALU_AND:  result = op1_i & op2_i;
            ALU_LUI:  result = op2_i;
            default:  result = '0;
        endcase
    end

    // strobe is dropped when an interrupt arrives with the issue
    always_ff @(posedge clk) begin
        if (rst_i) begin
            we_o <= 1'b0;
        end else begin
            we_o <= req_i && !int_assert_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            wdata_o <= result;
            waddr_o <= rd_i;
            id_o    <= id_i;
        end
    end

endmodule

//--- exu_bru.sv
// branch and jump resolver with interrupt redirect
`timescale 1ns/1ps

module exu_bru (
    input  logic                req_i,
    input  logic [2:0]          op_i,
    input  exu_pkg::reg_data_t  rs1_i,
    input  exu_pkg::reg_data_t  rs2_i,
    input  exu_pkg::inst_addr_t pc_i,
    input  exu_pkg::reg_data_t  imm_i,
    input  logic                int_assert_i,
    input  exu_pkg::inst_addr_t int_addr_i,
    output logic                jump_o,
    output exu_pkg::inst_addr_t jump_addr_o
);
    import exu_pkg::*;

    logic       eq;
    logic       lt;
    logic       ltu;
    logic       taken;
    inst_addr_t jalr_sum;
    inst_addr_t target;

    assign eq  = (rs1_i == rs2_i);
    assign lt  = ($signed(rs1_i) < $signed(rs2_i));
    assign ltu = (rs1_i < rs2_i);

    always_comb begin
        case (op_i)
            BJP_JAL, BJP_JALR: taken = 1'b1;
            BJP_BEQ:  taken = eq;
            BJP_BNE:  taken = !eq;
            BJP_BLT:  taken = lt;
            BJP_BGE:  taken = !lt;
            BJP_BLTU: taken = ltu;
            default:  taken = !ltu;  // bgeu
        endcase
    end

    assign jalr_sum = rs1_i + imm_i;
    assign target   = (op_i == BJP_JALR) ? {jalr_sum[31:1], 1'b0} : pc_i + imm_i;

    // interrupt wins over any branch in the same cycle
    assign jump_o      = int_assert_i || (req_i && taken);
    assign jump_addr_o = int_assert_i ? int_addr_i : target;

endmodule

//--- exu_muldiv.sv
// iterative multiply/divide unit, one-cycle multiply and restoring divider
`timescale 1ns/1ps

module exu_muldiv (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                req_i,
    input  exu_pkg::muldiv_op_t op_i,
    input  exu_pkg::reg_data_t  op1_i,
    input  exu_pkg::reg_data_t  op2_i,
    input  exu_pkg::reg_addr_t  rd_i,
    input  exu_pkg::inst_id_t   id_i,
    input  logic                int_assert_i,
    output logic                busy_o,
    output logic                we_o,
    output exu_pkg::reg_data_t  wdata_o,
    output exu_pkg::reg_addr_t  waddr_o,
    output exu_pkg::inst_id_t   id_o
);
    import exu_pkg::*;

    muldiv_state_e state_q;
    logic [5:0]    cnt_q;     // divide steps done
    muldiv_op_t    op_q;
    reg_data_t     a_q;       // raw operands
    reg_data_t     b_q;
    reg_data_t     quo_q;     // dividend shifting out, quotient shifting in
    reg_data_t     rem_q;
    reg_data_t     dvs_q;     // divisor magnitude
    reg_data_t     res_q;
    reg_addr_t     rd_q;
    inst_id_t      id_q;

    logic          is_div_req;
    logic          sgn_req;
    reg_data_t     abs_a;
    reg_data_t     abs_b;
    logic          a_sgn;
    logic          b_sgn;
    logic [65:0]   prod;
    logic [32:0]   rem_sh;
    logic          sub_ok;
    reg_data_t     rem_nxt;
    logic          div_signed;
    reg_data_t     quo_fix;
    reg_data_t     rem_fix;
    reg_data_t     div_res;

    // magnitudes are taken once, at issue
    assign is_div_req = (op_i == MD_DIV) || (op_i == MD_DIVU) ||
                        (op_i == MD_REM) || (op_i == MD_REMU);
    assign sgn_req    = (op_i == MD_DIV) || (op_i == MD_REM);
    assign abs_a      = (sgn_req && op1_i[31]) ? -op1_i : op1_i;
    assign abs_b      = (sgn_req && op2_i[31]) ? -op2_i : op2_i;

    // 33x33 signed product covers all four signedness mixes
    assign a_sgn = a_q[31] && (op_q != MD_MULHU);
    assign b_sgn = b_q[31] && ((op_q == MD_MUL) || (op_q == MD_MULH));
    assign prod  = $signed({a_sgn, a_q}) * $signed({b_sgn, b_q});

    assign rem_sh  = {rem_q, quo_q[31]};
    assign sub_ok  = (rem_sh >= {1'b0, dvs_q});
    assign rem_nxt = rem_sh[31:0] - dvs_q;

    assign div_signed = (op_q == MD_DIV) || (op_q == MD_REM);
    assign quo_fix = (div_signed && (a_q[31] ^ b_q[31])) ? -quo_q : quo_q;
    assign rem_fix = (div_signed && a_q[31]) ? -rem_q : rem_q;

    always_comb begin
        if (b_q == '0) begin
            div_res = ((op_q == MD_DIV) || (op_q == MD_DIVU)) ? '1 : a_q;
        end else begin
            div_res = ((op_q == MD_DIV) || (op_q == MD_DIVU)) ? quo_fix : rem_fix;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else if (int_assert_i) begin
            state_q <= ST_IDLE;  // kill whatever is in flight
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        state_q <= is_div_req ? ST_DIV : ST_MUL;
                        cnt_q   <= '0;
                    end
                end
                ST_MUL: state_q <= ST_DONE;
                ST_DIV: begin
                    if (cnt_q == DIV_STEPS) begin
                        state_q <= ST_DONE;  // sign fixup cycle
                    end
                    cnt_q <= cnt_q + 6'd1;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            ST_IDLE: begin
                if (req_i) begin
                    op_q  <= op_i;
                    a_q   <= op1_i;
                    b_q   <= op2_i;
                    quo_q <= abs_a;
                    dvs_q <= abs_b;
                    rem_q <= '0;
                    rd_q  <= rd_i;
                    id_q  <= id_i;
                end
            end
            ST_MUL: res_q <= (op_q == MD_MUL) ? prod[31:0] : prod[63:32];
            ST_DIV: begin
                if (cnt_q == DIV_STEPS) begin
                    res_q <= div_res;
                end else begin
                    rem_q <= sub_ok ? rem_nxt : rem_sh[31:0];
                    quo_q <= {quo_q[30:0], sub_ok};
                end
            end
            default: ;
        endcase
    end

    assign busy_o  = (state_q != ST_IDLE);
    assign we_o    = (state_q == ST_DONE) && !int_assert_i;
    assign wdata_o = res_q;
    assign waddr_o = rd_q;
    assign id_o    = id_q;

endmodule

//--- exu.sv
// execute stage top level, dispatch feeding alu, branch and muldiv units
`timescale 1ns/1ps

module exu (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                issue_i,
    input  exu_pkg::dec_info_t  dec_info_i,
    input  exu_pkg::reg_data_t  dec_imm_i,
    input  exu_pkg::inst_addr_t pc_i,
    input  exu_pkg::reg_data_t  rs1_data_i,
    input  exu_pkg::reg_data_t  rs2_data_i,
    input  exu_pkg::reg_addr_t  rd_i,
    input  exu_pkg::inst_id_t   inst_id_i,
    input  logic                int_assert_i,
    input  exu_pkg::inst_addr_t int_addr_i,
    output logic                alu_we_o,
    output exu_pkg::reg_data_t  alu_wdata_o,
    output exu_pkg::reg_addr_t  alu_waddr_o,
    output exu_pkg::inst_id_t   alu_id_o,
    output logic                md_we_o,
    output exu_pkg::reg_data_t  md_wdata_o,
    output exu_pkg::reg_addr_t  md_waddr_o,
    output exu_pkg::inst_id_t   md_id_o,
    output logic                stall_o,
    output logic                jump_o,
    output exu_pkg::inst_addr_t jump_addr_o,
    output logic                ecall_o,
    output logic                ebreak_o,
    output logic                mret_o
);
    import exu_pkg::*;

    logic       alu_req;
    alu_op_t    alu_op;
    reg_data_t  alu_op1;
    reg_data_t  alu_op2;
    logic       bjp_req;
    logic [2:0] bjp_op;
    logic       md_req;
    muldiv_op_t md_op;
    reg_data_t  md_op1;
    reg_data_t  md_op2;

    exu_dispatch u_dispatch (
        .issue_i    (issue_i),
        .dec_info_i (dec_info_i),
        .dec_imm_i  (dec_imm_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .alu_req_o  (alu_req),
        .alu_op_o   (alu_op),
        .alu_op1_o  (alu_op1),
        .alu_op2_o  (alu_op2),
        .bjp_req_o  (bjp_req),
        .bjp_op_o   (bjp_op),
        .md_req_o   (md_req),
        .md_op_o    (md_op),
        .md_op1_o   (md_op1),
        .md_op2_o   (md_op2),
        .ecall_o    (ecall_o),
        .ebreak_o   (ebreak_o),
        .mret_o     (mret_o)
    );

    exu_alu u_alu (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_i        (alu_req),
        .op_i         (alu_op),
        .op1_i        (alu_op1),
        .op2_i        (alu_op2),
        .rd_i         (rd_i),
        .id_i         (inst_id_i),
        .int_assert_i (int_assert_i),
        .we_o         (alu_we_o),
        .wdata_o      (alu_wdata_o),
        .waddr_o      (alu_waddr_o),
        .id_o         (alu_id_o)
    );

    // branch unit sees raw register and immediate values
    exu_bru u_bru (
        .req_i        (bjp_req),
        .op_i         (bjp_op),
        .rs1_i        (rs1_data_i),
        .rs2_i        (rs2_data_i),
        .pc_i         (pc_i),
        .imm_i        (dec_imm_i),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .jump_o       (jump_o),
        .jump_addr_o  (jump_addr_o)
    );

    exu_muldiv u_muldiv (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_i        (md_req),
        .op_i         (md_op),
        .op1_i        (md_op1),
        .op2_i        (md_op2),
        .rd_i         (rd_i),
        .id_i         (inst_id_i),
        .int_assert_i (int_assert_i),
        .busy_o       (stall_o),    // stall is the muldiv busy level
        .we_o         (md_we_o),
        .wdata_o      (md_wdata_o),
        .waddr_o      (md_waddr_o),
        .id_o         (md_id_o)
    );

endmodule

//--- exu_assertions.sv
// execute stage protocol checks on issue, stall and write strobes
`timescale 1ns/1ps

module exu_assertions (
    input logic               clk,
    input logic               rst_i,
    input logic               issue_i,
    input exu_pkg::dec_info_t dec_info_i,
    input logic               stall_i,
    input logic               alu_we_i,
    input logic               md_we_i,
    input logic               int_assert_i
);
    import exu_pkg::*;

    int   fail_count = 0;
    logic md_issue;

    assign md_issue = issue_i && (dec_info_i[DEC_GRP_LSB +: 3] == GRP_MULDIV);

    // alu and branch issues may overlap a muldiv, a second muldiv may not
    md_issue_no_stall: assert property (@(posedge clk) disable iff (rst_i)
        md_issue |-> !stall_i)
        else begin
            $error("muldiv issued while stall is high");
            fail_count = fail_count + 1;
        end

    alu_we_after_issue: assert property (@(posedge clk) disable iff (rst_i)
        alu_we_i |-> $past(issue_i))
        else begin
            $error("alu write strobe without an issue in the cycle before");
            fail_count = fail_count + 1;
        end

    md_we_after_busy: assert property (@(posedge clk) disable iff (rst_i)
        md_we_i |-> $past(stall_i))
        else begin
            $error("muldiv write strobe without a busy period");
            fail_count = fail_count + 1;
        end

    stall_fall_cause: assert property (@(posedge clk) disable iff (rst_i)
        $fell(stall_i) |-> ($past(md_we_i) || $past(int_assert_i)))
        else begin
            $error("stall dropped without a muldiv write or interrupt");
            fail_count = fail_count + 1;
        end

endmodule

bind exu exu_assertions u_chk (
    .clk          (clk),
    .rst_i        (rst_i),
    .issue_i      (issue_i),
    .dec_info_i   (dec_info_i),
    .stall_i      (stall_o),
    .alu_we_i     (alu_we_o),
    .md_we_i      (md_we_o),
    .int_assert_i (int_assert_i)
);

//--- tb_exu.sv
// execute stage testbench, LFSR driven issues checked against a reference model
`timescale 1ns/1ps

module tb_exu;
    import exu_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_ALU    = 40;
    localparam int NUM_BJP    = 30;
    localparam int NUM_MD     = 24;
    localparam int NUM_INSNS  = NUM_ALU + NUM_BJP + NUM_MD + 2 + 3;  // + interrupt and sys
    localparam int WATCHDOG_CYCLES = NUM_INSNS * (DIV_STEPS + 4) + 64;

    logic       clk;
    logic       rst_i;
    logic       issue_i;
    dec_info_t  dec_info_i;
    reg_data_t  dec_imm_i;
    inst_addr_t pc_i;
    reg_data_t  rs1_data_i;
    reg_data_t  rs2_data_i;
    reg_addr_t  rd_i;
    inst_id_t   inst_id_i;
    logic       int_assert_i;
    inst_addr_t int_addr_i;
    logic       alu_we_o;
    reg_data_t  alu_wdata_o;
    reg_addr_t  alu_waddr_o;
    inst_id_t   alu_id_o;
    logic       md_we_o;
    reg_data_t  md_wdata_o;
    reg_addr_t  md_waddr_o;
    inst_id_t   md_id_o;
    logic       stall_o;
    logic       jump_o;
    inst_addr_t jump_addr_o;
    logic       ecall_o;
    logic       ebreak_o;
    logic       mret_o;

    logic [31:0] lfsr_q = 32'h429a;
    logic        alu_pend;     // alu write due next cycle
    reg_data_t   alu_exp_data;
    reg_addr_t   alu_exp_addr;
    inst_id_t    alu_exp_id;
    logic        md_active;    // a muldiv write may show up

    exu dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic dec_info_t make_dec(input logic [2:0] grp, input logic use_imm,
                                           input logic use_pc, input logic [3:0] op);
        dec_info_t d;
        d = '0;
        d[DEC_GRP_LSB +: 3]  = grp;
        d[DEC_USE_IMM_BIT]   = use_imm;
        d[DEC_USE_PC_BIT]    = use_pc;
        d[DEC_OP_LSB +: 4]   = op;
        return d;
    endfunction

    function automatic reg_data_t alu_model(input alu_op_t op, input reg_data_t a,
                                            input reg_data_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return reg_data_t'($signed(a) >>> b[4:0]);
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_LUI:  return b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic bjp_taken(input logic [2:0] op, input reg_data_t a,
                                       input reg_data_t b);
        case (op)
            BJP_BEQ:  return a == b;
            BJP_BNE:  return a != b;
            BJP_BLT:  return $signed(a) < $signed(b);
            BJP_BGE:  return $signed(a) >= $signed(b);
            BJP_BLTU: return a < b;
            BJP_BGEU: return a >= b;
            default:  return 1'b1;  // jal, jalr
        endcase
    endfunction

    function automatic reg_data_t md_model(input muldiv_op_t op, input reg_data_t a,
                                           input reg_data_t b);
        logic [63:0] p_ss;
        logic [63:0] p_su;
        logic [63:0] p_uu;
        logic        ovf;
        // low 64 bits of extended operands give every signedness mix
        p_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        p_su = {{32{a[31]}}, a} * {32'd0, b};
        p_uu = {32'd0, a} * {32'd0, b};
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            MD_MUL:    return p_uu[31:0];
            MD_MULH:   return p_ss[63:32];
            MD_MULHSU: return p_su[63:32];
            MD_MULHU:  return p_uu[63:32];
            MD_DIV:    return (b == 0) ? '1 : ovf ? a : reg_data_t'($signed(a) / $signed(b));
            MD_DIVU:   return (b == 0) ? '1 : a / b;
            MD_REM:    return (b == 0) ? a : ovf ? '0 : reg_data_t'($signed(a) % $signed(b));
            default:   return (b == 0) ? a : a % b;
        endcase
    endfunction

    task automatic halt_on_error;
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic give_up(input string why);
        $display("ERROR @%0t: %s", $time, why);
        halt_on_error();
    endtask

    task automatic check_wb(input string what, input reg_data_t got_d, input reg_addr_t got_a,
                            input inst_id_t got_id, input reg_data_t exp_d,
                            input reg_addr_t exp_a, input inst_id_t exp_id);
        if (got_d !== exp_d || got_a !== exp_a || got_id !== exp_id) begin
            $display("FAILED @%0t: %s write %h rd %0d id %0d, expected %h rd %0d id %0d",
                     $time, what, got_d, got_a, got_id, exp_d, exp_a, exp_id);
            halt_on_error();
        end
    endtask

    task automatic check_jump(input logic got_j, input inst_addr_t got_a,
                              input logic exp_j, input inst_addr_t exp_a);
        if (got_j !== exp_j || (exp_j && got_a !== exp_a)) begin
            $display("FAILED @%0t: jump %b addr %h, expected jump %b addr %h",
                     $time, got_j, got_a, exp_j, exp_a);
            halt_on_error();
        end
    endtask

    task automatic check_sys(input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("FAILED @%0t: ecall/ebreak/mret %b, expected %b", $time, got, exp);
            halt_on_error();
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic go_idle;
        issue_i    = 1'b0;
        dec_info_i = '0;
        dec_imm_i  = '0;
        pc_i       = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        rd_i       = '0;
        inst_id_i  = '0;
    endtask

    task automatic send(input dec_info_t dec, input reg_data_t imm, input inst_addr_t pc,
                        input reg_data_t rs1, input reg_data_t rs2, input reg_addr_t rd,
                        input inst_id_t id);
        issue_i    = 1'b1;
        dec_info_i = dec;
        dec_imm_i  = imm;
        pc_i       = pc;
        rs1_data_i = rs1;
        rs2_data_i = rs2;
        rd_i       = rd;
        inst_id_i  = id;
    endtask

    task automatic expect_alu(input reg_data_t d, input reg_addr_t a, input inst_id_t id);
        alu_exp_data = d;
        alu_exp_addr = a;
        alu_exp_id   = id;
        alu_pend     = 1'b1;
    endtask

    task automatic issue_alu_random;
        alu_op_t    op;
        logic       use_imm;
        logic       use_pc;
        reg_data_t  imm;
        reg_data_t  rs1;
        reg_data_t  rs2;
        inst_addr_t pc;
        reg_addr_t  rd;
        inst_id_t   id;
        op      = alu_op_t'(rand_bits(4) % 11);
        use_imm = rand_bits(1);
        use_pc  = rand_bits(1);
        imm     = rand_bits(32);
        rs1     = rand_bits(32);
        rs2     = rand_bits(32);
        pc      = rand_bits(30) << 2;
        rd      = rand_bits(5);
        id      = rand_bits(2);
        send(make_dec(GRP_ALU, use_imm, use_pc, op), imm, pc, rs1, rs2, rd, id);
        expect_alu(alu_model(op, use_pc ? pc : rs1, use_imm ? imm : rs2), rd, id);
        #1;
        check_jump(jump_o, jump_addr_o, 1'b0, '0);
        check_sys({ecall_o, ebreak_o, mret_o}, 3'b000);
    endtask

    task automatic issue_bjp_random;
        logic [2:0] op;
        reg_data_t  rs1;
        reg_data_t  rs2;
        reg_data_t  imm;
        inst_addr_t pc;
        inst_addr_t target;
        reg_addr_t  rd;
        inst_id_t   id;
        op  = rand_bits(3);
        rs1 = rand_bits(32);
        rs2 = rand_bits(32);
        if (rand_bits(1)) begin
            rs2 = rs1;  // equal operands now and then
        end
        imm = reg_data_t'($signed(rand_bits(13) << 19) >>> 19);
        pc  = rand_bits(30) << 2;
        rd  = rand_bits(5);
        id  = rand_bits(2);
        target = (op == BJP_JALR) ? ((rs1 + imm) & ~32'd1) : pc + imm;
        send(make_dec(GRP_BJP, 1'b1, 1'b0, {1'b0, op}), imm, pc, rs1, rs2, rd, id);
        if (op == BJP_JAL || op == BJP_JALR) begin
            expect_alu(pc + 32'd4, rd, id);  // link value
        end
        #1;
        check_jump(jump_o, jump_addr_o, bjp_taken(op, rs1, rs2), target);
        check_sys({ecall_o, ebreak_o, mret_o}, 3'b000);
    endtask

    task automatic run_muldiv(input muldiv_op_t op, input reg_data_t a, input reg_data_t b);
        reg_data_t exp_d;
        reg_addr_t rd;
        inst_id_t  id;
        int        lat;
        int        waited;
        logic      done;
        rd     = rand_bits(5);
        id     = rand_bits(2);
        exp_d  = md_model(op, a, b);
        lat    = (op >= MD_DIV) ? DIV_STEPS + 2 : 2;
        waited = 0;
        done   = 1'b0;
        md_active = 1'b1;
        send(make_dec(GRP_MULDIV, 1'b0, 1'b0, {1'b0, op}), rand_bits(32), '0, a, b, rd, id);
        #1;
        check_jump(jump_o, jump_addr_o, 1'b0, '0);
        while (!done) begin
            @(posedge clk);
            #1;
            waited++;
            if (!stall_o) begin
                give_up("stall_o low while a multiply or divide was in flight");
            end else if (md_we_o) begin
                check_wb("muldiv", md_wdata_o, md_waddr_o, md_id_o, exp_d, rd, id);
                if (waited != lat) begin
                    $display("FAILED @%0t: muldiv took %0d cycles, expected %0d",
                             $time, waited, lat);
                    halt_on_error();
                end
                done = 1'b1;
            end else if (waited > DIV_STEPS + 4) begin
                give_up("muldiv write strobe never arrived");
            end
            #1;
            if (!done && rand_bits(1)) begin
                issue_alu_random();  // alu keeps going under stall
            end else begin
                go_idle();
            end
        end
        @(posedge clk);
        #1;
        if (stall_o) begin
            give_up("stall_o still high in the cycle after the muldiv write");
        end
        #1;
        md_active = 1'b0;
    endtask

    task automatic run_interrupt;
        inst_addr_t vec;
        vec = rand_bits(30) << 2;
        send(make_dec(GRP_MULDIV, 1'b0, 1'b0, {1'b0, MD_DIVU}), '0, '0, 32'd1000, 32'd7,
             5'd3, 2'd1);
        repeat (5) begin
            next_cycle();
            go_idle();
        end
        @(posedge clk);
        #1;
        if (!stall_o) begin
            give_up("divide did not raise stall_o");
        end
        #1;
        int_assert_i = 1'b1;
        int_addr_i   = vec;
        // this alu issue is killed by the interrupt
        send(make_dec(GRP_ALU, 1'b0, 1'b0, ALU_ADD), '0, '0, 32'd5, 32'd6, 5'd9, 2'd2);
        #1;
        check_jump(jump_o, jump_addr_o, 1'b1, vec);
        @(posedge clk);
        #1;
        if (stall_o) begin
            give_up("stall_o still high in the cycle after the interrupt");
        end
        #1;
        int_assert_i = 1'b0;
        go_idle();
        repeat (DIV_STEPS + 4) begin
            @(posedge clk);
            #1;
            if (stall_o) begin
                give_up("stall_o came back after the interrupt");
            end
        end
    endtask

    // write strobe monitor, samples just after the edge
    always begin
        @(posedge clk);
        #1;
        if (!rst_i) begin
            if (alu_pend) begin
                if (!alu_we_o) begin
                    give_up("ALU write strobe did not arrive in the cycle after issue");
                end else begin
                    check_wb("alu", alu_wdata_o, alu_waddr_o, alu_id_o,
                             alu_exp_data, alu_exp_addr, alu_exp_id);
                end
                alu_pend = 1'b0;
            end else if (alu_we_o) begin
                give_up("ALU write strobe without a matching issue");
            end
            if (md_we_o && !md_active) begin
                give_up("muldiv write strobe outside a multiply or divide");
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        give_up("watchdog expired before the tests finished");
    end

    initial begin
        muldiv_op_t op;
        reg_data_t  a;
        reg_data_t  b;
        logic [3:0] sys_op;
        rst_i        = 1'b1;
        int_assert_i = 1'b0;
        int_addr_i   = '0;
        alu_pend     = 1'b0;
        md_active    = 1'b0;
        go_idle();
        repeat (4) @(posedge clk);
        #2;
        rst_i = 1'b0;

        @(posedge clk);
        #1;
        check_jump(jump_o, jump_addr_o, 1'b0, '0);
        check_sys({ecall_o, ebreak_o, mret_o}, 3'b000);
        if (alu_we_o || md_we_o || stall_o) begin
            give_up("write strobe or stall active after reset");
        end
        #1;

        repeat (NUM_ALU) begin
            next_cycle();
            issue_alu_random();
        end
        repeat (NUM_BJP) begin
            next_cycle();
            issue_bjp_random();
        end
        next_cycle();
        go_idle();

        for (int i = 0; i < NUM_MD; i++) begin
            op = muldiv_op_t'(rand_bits(3));
            a  = rand_bits(32);
            b  = rand_bits(32);
            if (i % 6 == 1) begin
                op = muldiv_op_t'(MD_DIV + rand_bits(2));
                b  = '0;
            end else if (i % 6 == 3) begin
                op = rand_bits(1) ? MD_DIV : MD_REM;
                a  = 32'h8000_0000;
                b  = 32'hffff_ffff;
            end
            next_cycle();
            run_muldiv(op, a, b);
        end

        next_cycle();
        run_interrupt();

        for (int s = 0; s < 3; s++) begin
            sys_op = (s == 0) ? SYS_ECALL : (s == 1) ? SYS_EBREAK : SYS_MRET;
            next_cycle();
            send(make_dec(GRP_SYS, 1'b0, 1'b0, sys_op), '0, '0, '0, '0, rand_bits(5), '0);
            #1;
            check_sys({ecall_o, ebreak_o, mret_o},
                      {sys_op == SYS_ECALL, sys_op == SYS_EBREAK, sys_op == SYS_MRET});
            check_jump(jump_o, jump_addr_o, 1'b0, '0);
        end
        next_cycle();
        go_idle();
        repeat (3) next_cycle();  // let the monitor see trailing strobes

        if (dut0.u_chk.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("ERROR @%0t: %0d assertion failures", $time, dut0.u_chk.fail_count);
            halt_on_error();
        end
    end

endmodule

//--- filelist.f
exu_pkg.sv
exu_dispatch.sv
exu_alu.sv
exu_bru.sv
exu_muldiv.sv
exu.sv
exu_assertions.sv
tb_exu.sv

//--- Bender.yml
package:
  name: exu

sources:
  - exu_pkg.sv
  - exu_dispatch.sv
  - exu_alu.sv
  - exu_bru.sv
  - exu_muldiv.sv
  - exu.sv
  - target: test
    files:
      - exu_assertions.sv
      - tb_exu.sv
